//--- logic/speckle_pkg.sv
`default_nettype none

package speckle_pkg;

    // One ADC sample per pixel
    localparam int ADC_W = 12;

    typedef logic [ADC_W-1:0] pixel_t;

    // Cycles per strobe phase, a zero behaves as one
    localparam int DIV_W = 24;

    typedef logic [DIV_W-1:0] clk_div_t;

    typedef enum logic {
        MODE_SCAN   = 1'b0,
        MODE_CONFIG = 1'b1
    } mode_e;

    // Commands for the on-chip shift registers
    typedef enum logic [1:0] {
        CMD_ROW_RST = 2'd0,
        CMD_ROW_BIT = 2'd1,
        CMD_COL_BIT = 2'd2,
        CMD_KEY     = 2'd3
    } chip_cmd_e;

    typedef enum logic [3:0] {
        ST_IDLE    = 4'd0,
        ST_ISSUE   = 4'd1,
        ST_ACK     = 4'd2,
        ST_REL     = 4'd3,
        ST_ADC_ARM = 4'd4,
        ST_ADC     = 4'd5,
        ST_RD      = 4'd6,
        ST_DONE    = 4'd7
    } seq_state_e;

endpackage

`default_nettype wire

//--- logic/chip_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface chip_cmd_if;
    import speckle_pkg::*;

    logic      req;
    chip_cmd_e cmd;
    logic      bit_val;
    clk_div_t  clk_div;
    logic      ack;

    // Four-phase req/ack, cmd and bit_val held while req is high
    modport ctrl (
        output req,
        output cmd,
        output bit_val,
        output clk_div,
        input  ack
    );

    modport drv (
        input  req,
        input  cmd,
        input  bit_val,
        input  clk_div,
        output ack
    );

endinterface

`default_nettype wire

//--- logic/pixel_counter.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_counter #(
    parameter int N_ROWS = 24,
    parameter int N_COLS = 24
) (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_clear,
    input  logic                             i_advance_col,
    input  logic                             i_advance_row,
    output logic [$clog2(N_COLS)-1:0]        o_col_idx,
    output logic                             o_col_last,
    output logic                             o_row_last,
    output logic                             o_row_first,
    output logic [$clog2(N_ROWS*N_COLS)-1:0] o_addr
);
    localparam int COL_W  = $clog2(N_COLS);
    localparam int ROW_W  = $clog2(N_ROWS);
    localparam int ADDR_W = $clog2(N_ROWS * N_COLS);

    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_clear) begin
            col_q <= '0;
            row_q <= '0;
        end else begin
            if (i_advance_col) begin
                col_q <= o_col_last ? '0 : col_q + 1'b1;
            end
            if (i_advance_row) begin
                row_q <= o_row_last ? '0 : row_q + 1'b1;
            end
        end
    end

    assign o_col_idx   = col_q;
    assign o_col_last  = (col_q == COL_W'(N_COLS - 1));
    assign o_row_last  = (row_q == ROW_W'(N_ROWS - 1));
    assign o_row_first = (row_q == '0);

    // Row-major linear address
    assign o_addr = ADDR_W'(row_q) * ADDR_W'(N_COLS) + ADDR_W'(col_q);

    a_addr_range: assert property (@(posedge clk) disable iff (!i_rst_n)
        int'(o_addr) < N_ROWS * N_COLS);

endmodule

`default_nettype wire

//--- logic/pixel_ram.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_ram #(
    parameter int N_ROWS = 24,
    parameter int N_COLS = 24
) (
    input  logic                             clk,
    input  logic                             i_we,
    input  logic                             i_re,
    input  logic [$clog2(N_ROWS*N_COLS)-1:0] i_addr,
    input  speckle_pkg::pixel_t              i_wdata,
    output speckle_pkg::pixel_t              o_rdata
);
    import speckle_pkg::*;

    localparam int DEPTH = N_ROWS * N_COLS;

    pixel_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // Registered read, data held between reads
    always_ff @(posedge clk) begin
        if (i_re) begin
            o_rdata <= mem[i_addr];
        end
    end

endmodule

`default_nettype wire

//--- logic/chip_driver.sv
`timescale 1ns/1ps
`default_nettype none

module chip_driver (
    input  logic    clk,
    input  logic    i_rst_n,
    chip_cmd_if.drv chip,
    output logic    o_row_clk,
    output logic    o_row_data,
    output logic    o_row_rst,
    output logic    o_col_clk,
    output logic    o_col_data,
    output logic    o_key_wren
);
    import speckle_pkg::*;

    typedef enum logic [2:0] {
        DRV_IDLE,
        DRV_SETUP,
        DRV_HIGH,
        DRV_LOW,
        DRV_ACK
    } drv_state_e;

    drv_state_e state;
    clk_div_t   cnt_q;
    clk_div_t   div_eff;
    logic [3:0] strobe_q;

    assign div_eff = (chip.clk_div == '0) ? clk_div_t'(1) : chip.clk_div;

    // One strobe per command code
    assign o_row_rst  = strobe_q[CMD_ROW_RST];
    assign o_row_clk  = strobe_q[CMD_ROW_BIT];
    assign o_col_clk  = strobe_q[CMD_COL_BIT];
    assign o_key_wren = strobe_q[CMD_KEY];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state      <= DRV_IDLE;
            cnt_q      <= '0;
            strobe_q   <= '0;
            o_row_data <= 1'b0;
            o_col_data <= 1'b0;
            chip.ack   <= 1'b0;
        end else begin
            case (state)
                DRV_IDLE: begin
                    // Data goes out one cycle ahead of the strobe
                    if (chip.req) begin
                        o_row_data <= (chip.cmd == CMD_ROW_BIT) && chip.bit_val;
                        o_col_data <= (chip.cmd == CMD_COL_BIT) && chip.bit_val;
                        state      <= DRV_SETUP;
                    end
                end
                DRV_SETUP: begin
                    strobe_q[chip.cmd] <= 1'b1;
                    cnt_q              <= div_eff - 1'b1;
                    state              <= DRV_HIGH;
                end
                DRV_HIGH: begin
                    if (cnt_q == '0) begin
                        strobe_q   <= '0;
                        o_row_data <= 1'b0;
                        o_col_data <= 1'b0;
                        cnt_q      <= div_eff - 1'b1;
                        state      <= DRV_LOW;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                DRV_LOW: begin
                    if (cnt_q == '0) begin
                        chip.ack <= 1'b1;
                        state    <= DRV_ACK;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                DRV_ACK: begin
                    if (!chip.req) begin
                        chip.ack <= 1'b0;
                        state    <= DRV_IDLE;
                    end
                end
                default: state <= DRV_IDLE;
            endcase
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
        chip.req && !chip.ack |=> chip.req);

    a_cmd_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        chip.req |=> !chip.req || ($stable(chip.cmd) && $stable(chip.bit_val)));

endmodule

`default_nettype wire

//--- logic/sensor_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_sequencer #(
    parameter int N_ROWS = 24,
    parameter int N_COLS = 24
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_start,
    input  speckle_pkg::mode_e        i_mode,
    input  speckle_pkg::pixel_t       i_threshold,
    input  speckle_pkg::clk_div_t     i_clk_div,
    input  speckle_pkg::pixel_t       i_adc_val,
    input  logic                      i_adc_done,
    input  logic                      i_col_last,
    input  logic                      i_row_last,
    input  logic                      i_row_first,
    input  logic [$clog2(N_COLS)-1:0] i_col_idx,
    input  speckle_pkg::pixel_t       i_ram_rdata,
    output logic                      o_busy,
    output logic                      o_done,
    output logic                      o_adc_trigger,
    output logic                      o_cnt_clear,
    output logic                      o_cnt_advance_col,
    output logic                      o_cnt_advance_row,
    output logic                      o_ram_we,
    output logic                      o_ram_re,
    output speckle_pkg::pixel_t       o_ram_wdata,
    chip_cmd_if.ctrl                  chip
);
    import speckle_pkg::*;

    seq_state_e state;
    mode_e      mode_q;
    pixel_t     thr_q;
    clk_div_t   div_q;
    logic       start_q;
    logic       start_rise;
    logic       rel_done;
    logic       adc_fin;
    logic       col_bit;

    // Counter widths need at least two entries per dimension
    if (N_ROWS < 2 || N_COLS < 2) begin : g_size_check
        $error("Pixel array needs at least two rows and two columns");
    end

    assign start_rise = i_start && !start_q;
    assign rel_done   = (state == ST_REL) && !chip.ack;
    assign adc_fin    = (state == ST_ADC) && i_adc_done;

    // Column-0 marker in scan, threshold compare in config
    assign col_bit = (mode_q == MODE_SCAN) ? (i_col_idx == '0) : (i_ram_rdata >= thr_q);

    assign o_cnt_clear = (state == ST_IDLE) && start_rise;

    // Config holds the last column until the key write is done
    assign o_cnt_advance_col = adc_fin
        || (rel_done && chip.cmd == CMD_KEY)
        || (rel_done && chip.cmd == CMD_COL_BIT && mode_q == MODE_CONFIG && !i_col_last);
    assign o_cnt_advance_row = (adc_fin && i_col_last) || (rel_done && chip.cmd == CMD_KEY);

    // Sample goes to memory in the cycle done is seen
    assign o_ram_we    = adc_fin;
    assign o_ram_wdata = i_adc_val;
    assign o_ram_re    = (state == ST_RD);

    assign chip.clk_div = div_q;

    // Run settings
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start_rise) begin
            mode_q <= i_mode;
            thr_q  <= i_threshold;
            div_q  <= i_clk_div;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state         <= ST_IDLE;
            start_q       <= 1'b0;
            o_busy        <= 1'b0;
            o_done        <= 1'b0;
            o_adc_trigger <= 1'b0;
            chip.req      <= 1'b0;
            chip.cmd      <= CMD_ROW_RST;
            chip.bit_val  <= 1'b0;
        end else begin
            start_q <= i_start;
            case (state)
                ST_IDLE: begin
                    if (start_rise) begin
                        o_busy   <= 1'b1;
                        chip.cmd <= CMD_ROW_RST;
                        state    <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    case (chip.cmd)
                        CMD_ROW_BIT: chip.bit_val <= i_row_first;
                        CMD_COL_BIT: chip.bit_val <= col_bit;
                        default:     chip.bit_val <= 1'b0;
                    endcase
                    chip.req <= 1'b1;
                    state    <= ST_ACK;
                end
                ST_ACK: begin
                    if (chip.ack) begin
                        chip.req <= 1'b0;
                        state    <= ST_REL;
                    end
                end
                ST_REL: begin
                    // Next step once the driver has dropped ack
                    if (!chip.ack) begin
                        case (chip.cmd)
                            CMD_ROW_RST: begin
                                chip.cmd <= CMD_ROW_BIT;
                                state    <= ST_ISSUE;
                            end
                            CMD_ROW_BIT: begin
                                if (mode_q == MODE_SCAN) begin
                                    chip.cmd <= CMD_COL_BIT;
                                    state    <= ST_ISSUE;
                                end else begin
                                    state <= ST_RD;
                                end
                            end
                            CMD_COL_BIT: begin
                                if (mode_q == MODE_SCAN) begin
                                    state <= ST_ADC_ARM;
                                end else if (i_col_last) begin
                                    chip.cmd <= CMD_KEY;
                                    state    <= ST_ISSUE;
                                end else begin
                                    state <= ST_RD;
                                end
                            end
                            default: begin
                                if (i_row_last) begin
                                    o_busy <= 1'b0;
                                    o_done <= 1'b1;
                                    state  <= ST_DONE;
                                end else begin
                                    chip.cmd <= CMD_ROW_BIT;
                                    state    <= ST_ISSUE;
                                end
                            end
                        endcase
                    end
                end
                ST_ADC_ARM: begin
                    // Previous conversion must be released first
                    if (!i_adc_done) begin
                        o_adc_trigger <= 1'b1;
                        state         <= ST_ADC;
                    end
                end
                ST_ADC: begin
                    if (i_adc_done) begin
                        o_adc_trigger <= 1'b0;
                        if (i_col_last && i_row_last) begin
                            o_busy <= 1'b0;
                            o_done <= 1'b1;
                            state  <= ST_DONE;
                        end else begin
                            chip.cmd <= i_col_last ? CMD_ROW_BIT : CMD_COL_BIT;
                            state    <= ST_ISSUE;
                        end
                    end
                end
                ST_RD: begin
                    chip.cmd <= CMD_COL_BIT;
                    state    <= ST_ISSUE;
                end
                ST_DONE: begin
                    if (!i_start) begin
                        o_done <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ADC and chip transfers never overlap
    a_trig_no_cmd: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_adc_trigger |-> !chip.req && !chip.ack);

endmodule

`default_nettype wire

//--- logic/speckle_sensor_controller.sv
`timescale 1ns/1ps
`default_nettype none

module speckle_sensor_controller #(
    parameter int N_ROWS = 24,
    parameter int N_COLS = 24
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  speckle_pkg::mode_e    i_mode,
    input  speckle_pkg::pixel_t   i_threshold,
    input  speckle_pkg::clk_div_t i_clk_div,
    input  speckle_pkg::pixel_t   i_adc_val,
    input  logic                  i_adc_done,
    output logic                  o_busy,
    output logic                  o_done,
    output logic                  o_adc_trigger,
    output logic                  o_row_clk,
    output logic                  o_row_data,
    output logic                  o_row_rst,
    output logic                  o_col_clk,
    output logic                  o_col_data,
    output logic                  o_key_wren
);
    import speckle_pkg::*;

    localparam int COL_W  = $clog2(N_COLS);
    localparam int ADDR_W = $clog2(N_ROWS * N_COLS);

    logic              cnt_clear;
    logic              cnt_advance_col;
    logic              cnt_advance_row;
    logic              col_last;
    logic              row_last;
    logic              row_first;
    logic [COL_W-1:0]  col_idx;
    logic [ADDR_W-1:0] ram_addr;
    logic              ram_we;
    logic              ram_re;
    pixel_t            ram_wdata;
    pixel_t            ram_rdata;

    chip_cmd_if chip_cmd ();

    sensor_sequencer #(
        .N_ROWS (N_ROWS),
        .N_COLS (N_COLS)
    ) u_sensor_sequencer (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_start           (i_start),
        .i_mode            (i_mode),
        .i_threshold       (i_threshold),
        .i_clk_div         (i_clk_div),
        .i_adc_val         (i_adc_val),
        .i_adc_done        (i_adc_done),
        .i_col_last        (col_last),
        .i_row_last        (row_last),
        .i_row_first       (row_first),
        .i_col_idx         (col_idx),
        .i_ram_rdata       (ram_rdata),
        .o_busy            (o_busy),
        .o_done            (o_done),
        .o_adc_trigger     (o_adc_trigger),
        .o_cnt_clear       (cnt_clear),
        .o_cnt_advance_col (cnt_advance_col),
        .o_cnt_advance_row (cnt_advance_row),
        .o_ram_we          (ram_we),
        .o_ram_re          (ram_re),
        .o_ram_wdata       (ram_wdata),
        .chip              (chip_cmd.ctrl)
    );

    pixel_counter #(
        .N_ROWS (N_ROWS),
        .N_COLS (N_COLS)
    ) u_pixel_counter (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_clear       (cnt_clear),
        .i_advance_col (cnt_advance_col),
        .i_advance_row (cnt_advance_row),
        .o_col_idx     (col_idx),
        .o_col_last    (col_last),
        .o_row_last    (row_last),
        .o_row_first   (row_first),
        .o_addr        (ram_addr)
    );

    pixel_ram #(
        .N_ROWS (N_ROWS),
        .N_COLS (N_COLS)
    ) u_pixel_ram (
        .clk     (clk),
        .i_we    (ram_we),
        .i_re    (ram_re),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

    chip_driver u_chip_driver (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .chip       (chip_cmd.drv),
        .o_row_clk  (o_row_clk),
        .o_row_data (o_row_data),
        .o_row_rst  (o_row_rst),
        .o_col_clk  (o_col_clk),
        .o_col_data (o_col_data),
        .o_key_wren (o_key_wren)
    );

endmodule

`default_nettype wire

//--- testbench/tb_speckle_sensor_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_speckle_sensor_controller;
    import speckle_pkg::*;

    localparam int N_ROWS = 4;
    localparam int N_COLS = 4;
    localparam int N_PIX  = N_ROWS * N_COLS;
    // Three runs at divider 3 take about 16 pixels x 25 cycles each, the rest is margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     start;
    mode_e    mode;
    pixel_t   threshold;
    clk_div_t clk_div;
    pixel_t   adc_val = '0;
    logic     adc_done = 1'b0;
    logic     busy;
    logic     done;
    logic     adc_trigger;
    logic     row_clk;
    logic     row_data;
    logic     row_rst;
    logic     col_clk;
    logic     col_data;
    logic     key_wren;

    // Chip monitor state, cleared at each run start
    logic     start_prev = 1'b0;
    mode_e    mode_q = MODE_SCAN;
    pixel_t   thr_q = '0;
    clk_div_t div_q = '0;
    int       rst_cnt = 0;
    int       row_cnt = 0;
    int       col_cnt = 0;
    int       key_cnt = 0;
    int       trig_cnt = 0;
    int       high_len = 0;
    int       exp_div;
    logic     any_strobe;
    logic     exp_cfg_bit;

    // ADC model state
    logic     adc_busy = 1'b0;
    int       adc_wait = 0;
    int       adc_hold = 0;
    int       adc_idx = 0;
    pixel_t   samples [N_PIX];

    int       errors = 0;
    int       runs_done = 0;
    int       cycles = 0;

    speckle_sensor_controller #(
        .N_ROWS (N_ROWS),
        .N_COLS (N_COLS)
    ) u_speckle_sensor_controller (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_start       (start),
        .i_mode        (mode),
        .i_threshold   (threshold),
        .i_clk_div     (clk_div),
        .i_adc_val     (adc_val),
        .i_adc_done    (adc_done),
        .o_busy        (busy),
        .o_done        (done),
        .o_adc_trigger (adc_trigger),
        .o_row_clk     (row_clk),
        .o_row_data    (row_data),
        .o_row_rst     (row_rst),
        .o_col_clk     (col_clk),
        .o_col_data    (col_data),
        .o_key_wren    (key_wren)
    );

    always #4 clk = ~clk;

    assign any_strobe  = row_clk || row_rst || col_clk || key_wren;
    assign exp_div     = (div_q == '0) ? 1 : int'(div_q);
    // Threshold rule on the sample recorded for this pixel
    assign exp_cfg_bit = (col_cnt < N_PIX) ? (samples[col_cnt] >= thr_q) : 1'b0;

    task automatic log_failure(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    // Counts strobes per run and measures each strobe's high phase
    always @(posedge clk) begin
        start_prev <= start;
        if (start && !start_prev) begin
            mode_q   <= mode;
            thr_q    <= threshold;
            div_q    <= clk_div;
            rst_cnt  <= 0;
            row_cnt  <= 0;
            col_cnt  <= 0;
            key_cnt  <= 0;
            trig_cnt <= 0;
        end else begin
            if (row_rst && !$past(row_rst)) rst_cnt <= rst_cnt + 1;
            if (row_clk && !$past(row_clk)) row_cnt <= row_cnt + 1;
            if (col_clk && !$past(col_clk)) col_cnt <= col_cnt + 1;
            if (key_wren && !$past(key_wren)) key_cnt <= key_cnt + 1;
            if (adc_trigger && !$past(adc_trigger)) trig_cnt <= trig_cnt + 1;
        end
        high_len <= any_strobe ? high_len + 1 : 0;
    end

    // ADC answers after 1 to 6 cycles, sample is placed on the bus when armed
    // Done may linger up to 16 cycles after the trigger falls
    always @(posedge clk) begin
        if (!rst_n) begin
            adc_done <= 1'b0;
            adc_busy <= 1'b0;
            adc_wait <= 0;
            adc_hold <= 0;
        end else if (adc_done) begin
            if (!adc_trigger) begin
                if (adc_hold == 0) begin
                    adc_done <= 1'b0;
                end else begin
                    adc_hold <= adc_hold - 1;
                end
            end
        end else if (adc_trigger && !adc_busy) begin
            adc_busy <= 1'b1;
            adc_wait <= $urandom_range(5, 0);
            adc_val  <= pixel_t'($urandom_range(4095, 0));
        end else if (adc_busy) begin
            if (adc_wait == 0) begin
                if (adc_idx < N_PIX) samples[adc_idx] <= adc_val;
                adc_idx  <= adc_idx + 1;
                adc_done <= 1'b1;
                adc_busy <= 1'b0;
                adc_hold <= $urandom_range(15, 0);
            end else begin
                adc_wait <= adc_wait - 1;
            end
        end
        if (row_rst) adc_idx <= 0;
    end

    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> !busy && !done && !adc_trigger && !any_strobe && !row_data && !col_data)
        else log_failure("outputs not low after reset");
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !any_strobe && !adc_trigger)
        else log_failure("strobe or trigger while idle");
    a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(start) && !busy && !done |=> busy)
        else log_failure("busy did not follow start");
    a_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !busy)
        else log_failure("done and busy both high");
    a_done_hold: assert property (@(posedge clk) disable iff (!rst_n)
        done && start |=> done)
        else log_failure("done dropped while start high");
    a_done_fall: assert property (@(posedge clk) disable iff (!rst_n)
        done && !start |=> !done)
        else log_failure("done did not fall after start fell");
    a_row_rst: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(row_rst) |-> rst_cnt == 0 && row_cnt == 0 && col_cnt == 0)
        else log_failure("row reset not first in run");
    a_row_bit: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(row_clk) |-> row_data == (row_cnt == 0) && rst_cnt == 1
            && col_cnt == row_cnt * N_COLS)
        else log_failure("row clock data or order wrong");
    a_col_row: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(col_clk) |-> col_cnt < row_cnt * N_COLS)
        else log_failure("column clock beyond current row");
    a_scan_col: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(col_clk) && mode_q == MODE_SCAN |->
            col_data == (col_cnt % N_COLS == 0) && trig_cnt == col_cnt)
        else log_failure("scan column bit or trigger count wrong");
    a_cfg_col: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(col_clk) && mode_q == MODE_CONFIG |-> col_data == exp_cfg_bit)
        else log_failure("config column bit differs from threshold result");
    a_key: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(key_wren) |-> mode_q == MODE_CONFIG && col_cnt == row_cnt * N_COLS
            && key_cnt == row_cnt - 1)
        else log_failure("key write out of place");
    a_trig_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(adc_trigger) |-> mode_q == MODE_SCAN && trig_cnt == col_cnt - 1 && !adc_done)
        else log_failure("trigger rise out of place");
    a_trig_hold: assert property (@(posedge clk) disable iff (!rst_n)
        adc_trigger && !adc_done |=> adc_trigger)
        else log_failure("trigger fell before done");
    a_trig_fall: assert property (@(posedge clk) disable iff (!rst_n)
        adc_trigger && adc_done |=> !adc_trigger)
        else log_failure("trigger stayed high after done");
    a_strobe_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(any_strobe) |-> high_len == exp_div)
        else log_failure("strobe high phase length wrong");
    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        any_strobe |-> $stable(row_data) && $stable(col_data))
        else log_failure("data line changed during strobe");
    a_run_counts: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> start && rst_cnt == 1 && row_cnt == N_ROWS && col_cnt == N_PIX
            && key_cnt == ((mode_q == MODE_CONFIG) ? N_ROWS : 0)
            && trig_cnt == ((mode_q == MODE_SCAN) ? N_PIX : 0))
        else log_failure("run ended with wrong strobe counts");

    task automatic run_frame(input mode_e run_mode, input pixel_t thr, input clk_div_t div);
        @(posedge clk);
        mode      <= run_mode;
        threshold <= thr;
        clk_div   <= div;
        start     <= 1'b1;
        do @(posedge clk); while (!done);
        repeat (3) @(posedge clk);
        start <= 1'b0;
        do @(posedge clk); while (done);
        runs_done++;
    endtask

    task automatic abort_scan(input clk_div_t div);
        @(posedge clk);
        mode    <= MODE_SCAN;
        clk_div <= div;
        start   <= 1'b1;
        do @(posedge clk); while (!busy);
        do @(posedge clk); while (col_cnt < 6);
        rst_n <= 1'b0;
        start <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", TIMEOUT_CYCLES);
            $display("Runs completed: %0d, errors: %0d", runs_done, errors);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(26243));
        rst_n     = 1'b0;
        start     = 1'b0;
        mode      = MODE_SCAN;
        threshold = '0;
        clk_div   = clk_div_t'(1);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        run_frame(MODE_SCAN, '0, clk_div_t'(1));
        run_frame(MODE_CONFIG, pixel_t'($urandom_range(3071, 1024)), clk_div_t'(1));
        run_frame(MODE_SCAN, '0, clk_div_t'(3));
        abort_scan(clk_div_t'(3));
        run_frame(MODE_SCAN, '0, clk_div_t'(3));
        run_frame(MODE_CONFIG, pixel_t'($urandom_range(3071, 1024)), clk_div_t'(3));
        repeat (4) @(posedge clk);
        $display("Runs completed: %0d, errors: %0d", runs_done, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
logic/speckle_pkg.sv
logic/chip_cmd_if.sv
logic/pixel_counter.sv
logic/pixel_ram.sv
logic/chip_driver.sv
logic/sensor_sequencer.sv
logic/speckle_sensor_controller.sv
testbench/tb_speckle_sensor_controller.sv

//--- Bender.yml
package:
  name: speckle_sensor_controller

sources:
  - logic/speckle_pkg.sv
  - logic/chip_cmd_if.sv
  - logic/pixel_counter.sv
  - logic/pixel_ram.sv
  - logic/chip_driver.sv
  - logic/sensor_sequencer.sv
  - logic/speckle_sensor_controller.sv
  - target: test
    files:
      - testbench/tb_speckle_sensor_controller.sv
